// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= pc_gen_tb
FILELIST ?= list.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== list.f ====
source/fetch_pkg.sv
source/rv_isa_pkg.sv
source/instr_predecode.sv
source/branch_predict.sv
source/resolve_fifo.sv
source/return_stack.sv
source/pc_gen.sv
testbench/pc_gen_checker.sv
testbench/pc_gen_tb.sv

// ==== source/branch_predict.sv ====
// static branch prediction and next pc

`timescale 1ns/10ps

module branch_predict (
	input logic [fetch_pkg::xlen-1:0] fetch_pc,
	input fetch_pkg::predecode_t pd,
	input logic exception,
	input logic [fetch_pkg::xlen-1:0] exception_pc,
	input logic jalr_valid,
	input logic [fetch_pkg::xlen-1:0] jalr_pc,
	input logic bru_valid,
	input logic bru_taken,
	input logic queue_full,
	input logic fetch_ready,
	input fetch_pkg::bq_entry_t bq_out,
	input logic bq_full,
	input logic [fetch_pkg::xlen-1:0] ras_top,
	input logic ras_empty,
	output logic [fetch_pkg::xlen-1:0] pc_next,
	output logic fetch_valid,
	output logic mispredict,
	output logic bq_push,
	output logic bq_pop,
	output fetch_pkg::bq_entry_t bq_in,
	output logic ras_push,
	output logic ras_pop,
	output logic [fetch_pkg::xlen-1:0] ras_push_addr,
	output logic flush
);

	logic [fetch_pkg::xlen-1:0] seq_pc;  // fall-through
	logic [fetch_pkg::xlen-1:0] take_pc; // predicted target
	logic taken;
	logic ret_ok; // return that the stack can serve
	logic bq_stall;
	logic jalr_stall;
	logic hold;
	logic redirect;
	logic fetch_go; // word accepted on the predicted path

	assign seq_pc = fetch_pc + (pd.is_rvc ? 64'd2 : 64'd4);
	assign ret_ok = pd.is_return & ~ras_empty;

	// backward branches taken, forward not taken
	assign taken = pd.is_jal | pd.is_jalr | (pd.is_branch & pd.imm[fetch_pkg::xlen-1]);

	always_comb begin
		if (pd.is_jalr) begin
			take_pc = ret_ok ? ras_top : jalr_pc;
		end else begin
			take_pc = fetch_pc + pd.imm;
		end
	end

	// oldest queue entry is the branch being resolved
	assign mispredict = bru_valid & (bru_taken ^ bq_out.pred_taken);
	assign redirect = exception | mispredict;
	assign flush = redirect;

	assign bq_stall = pd.is_branch & bq_full;
	assign jalr_stall = pd.is_jalr & ~ret_ok & ~jalr_valid; // wait for execute
	assign hold = bq_stall | jalr_stall | queue_full | ~fetch_ready;

	assign fetch_valid = ~hold | redirect;
	assign fetch_go = ~hold & ~redirect;

	assign bq_push = pd.is_branch & fetch_go;
	assign bq_pop = bru_valid;

	always_comb begin
		bq_in.pred_taken = taken;
		bq_in.alt_pc = taken ? seq_pc : take_pc; // keep the other path
	end

	assign ras_push = pd.is_call & fetch_go;
	assign ras_push_addr = seq_pc;
	assign ras_pop = ret_ok & fetch_go;

	always_comb begin
		if (exception) begin
			pc_next = exception_pc;
		end else if (mispredict) begin
			pc_next = bq_out.alt_pc;
		end else if (hold) begin
			pc_next = fetch_pc;
		end else if (taken) begin
			pc_next = take_pc;
		end else begin
			pc_next = seq_pc;
		end
	end

endmodule

// ==== source/fetch_pkg.sv ====
// fetch unit definitions

package fetch_pkg;

	// start address after reset
	localparam logic [63:0] reset_vector = 64'h0000_0000_8000_0000;

	localparam int xlen = 64; // address width

	localparam int bq_aw = 4;  // resolve queue, 16 entries
	localparam int ras_aw = 4; // return stack, 16 entries

	// predecode result for one fetched word
	typedef struct packed {
		logic is_jal;
		logic is_jalr;
		logic is_branch;
		logic is_call;   // jal/jalr linking to x1 or x5
		logic is_return; // jalr through x1 or x5 with rd = x0
		logic is_rvc;    // selects a step of 2
		logic [xlen-1:0] imm; // sign extended
	} predecode_t;

	// one predicted conditional branch waiting for the branch unit
	typedef struct packed {
		logic pred_taken;
		logic [xlen-1:0] alt_pc; // path not followed
	} bq_entry_t;

endpackage

// ==== source/instr_predecode.sv ====
// control transfer predecoder

`timescale 1ns/10ps

module instr_predecode (
	input rv_isa_pkg::rv_instr_u instr,
	output fetch_pkg::predecode_t pd
);

	logic rvc;
	logic rd_link; // rd is x1 or x5
	logic rs1_link;

	// compressed words have low bits other than 2'b11
	assign rvc = (instr.i.opcode[1:0] != 2'b11);

	assign rd_link = (instr.i.rd == rv_isa_pkg::reg_ra) || (instr.i.rd == rv_isa_pkg::reg_t0);
	assign rs1_link = (instr.i.rs1 == rv_isa_pkg::reg_ra) ||
		(instr.i.rs1 == rv_isa_pkg::reg_t0);

	always_comb begin
		pd = '0;
		pd.is_rvc = rvc;
		if (!rvc) begin
			case (instr.i.opcode)
				rv_isa_pkg::op_jal: begin
					pd.is_jal = 1'b1;
					pd.is_call = rd_link;
					pd.imm = {{44{instr.j.imm20}}, instr.j.imm19_12, instr.j.imm11,
						instr.j.imm10_1, 1'b0};
				end
				rv_isa_pkg::op_branch: begin
					pd.is_branch = 1'b1;
					pd.imm = {{52{instr.b.imm12}}, instr.b.imm11, instr.b.imm10_5,
						instr.b.imm4_1, 1'b0};
				end
				rv_isa_pkg::op_jalr: begin
					pd.is_jalr = 1'b1;
					pd.is_call = rd_link;
					// ret: jalr x0, 0(ra)
					pd.is_return = rs1_link && (instr.i.rd == rv_isa_pkg::reg_zero);
					pd.imm = {{52{instr.i.imm11_0[11]}}, instr.i.imm11_0};
				end
				default: ; // not a control transfer
			endcase
		end
	end

endmodule

// ==== source/pc_gen.sv ====
// fetch address generator

`timescale 1ns/10ps

module pc_gen (
	input logic CLK,
	input logic rst_n,
	input logic [31:0] instr,
	input logic fetch_ready,
	input logic queue_full,
	input logic exception,
	input logic [fetch_pkg::xlen-1:0] exception_pc,
	input logic jalr_valid,
	input logic [fetch_pkg::xlen-1:0] jalr_pc,
	input logic bru_valid,
	input logic bru_taken,
	output logic [fetch_pkg::xlen-1:0] fetch_pc,
	output logic fetch_valid,
	output logic mispredict
);

	fetch_pkg::predecode_t pd;
	fetch_pkg::bq_entry_t bq_in;
	fetch_pkg::bq_entry_t bq_out;
	logic [fetch_pkg::xlen-1:0] pc_next;
	logic [fetch_pkg::xlen-1:0] ras_top;
	logic [fetch_pkg::xlen-1:0] ras_push_addr;
	logic bq_push;
	logic bq_pop;
	logic bq_full;
	logic ras_push;
	logic ras_pop;
	logic ras_empty;
	logic flush; // mispredict or exception

	always_ff @(posedge CLK) begin
		if (!rst_n) fetch_pc <= fetch_pkg::reset_vector;
		else fetch_pc <= pc_next;
	end

	instr_predecode u_predecode (
		.instr (instr),
		.pd    (pd)
	);

	branch_predict u_predict (
		.fetch_pc      (fetch_pc),
		.pd            (pd),
		.exception     (exception),
		.exception_pc  (exception_pc),
		.jalr_valid    (jalr_valid),
		.jalr_pc       (jalr_pc),
		.bru_valid     (bru_valid),
		.bru_taken     (bru_taken),
		.queue_full    (queue_full),
		.fetch_ready   (fetch_ready),
		.bq_out        (bq_out),
		.bq_full       (bq_full),
		.ras_top       (ras_top),
		.ras_empty     (ras_empty),
		.pc_next       (pc_next),
		.fetch_valid   (fetch_valid),
		.mispredict    (mispredict),
		.bq_push       (bq_push),
		.bq_pop        (bq_pop),
		.bq_in         (bq_in),
		.ras_push      (ras_push),
		.ras_pop       (ras_pop),
		.ras_push_addr (ras_push_addr),
		.flush         (flush)
	);

	resolve_fifo u_bq (
		.CLK   (CLK),
		.rst_n (rst_n),
		.flush (flush),
		.push  (bq_push),
		.pop   (bq_pop),
		.din   (bq_in),
		.dout  (bq_out),
		.full  (bq_full),
		.empty ()
	);

	return_stack u_ras (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.flush     (flush),
		.push      (ras_push),
		.pop       (ras_pop),
		.push_addr (ras_push_addr),
		.top       (ras_top),
		.empty     (ras_empty)
	);

endmodule

// ==== source/resolve_fifo.sv ====
// branch resolve queue

`timescale 1ns/10ps

module resolve_fifo (
	input logic CLK,
	input logic rst_n,
	input logic flush,
	input logic push,
	input logic pop,
	input fetch_pkg::bq_entry_t din,
	output fetch_pkg::bq_entry_t dout,
	output logic full,
	output logic empty
);

	fetch_pkg::bq_entry_t mem [1 << fetch_pkg::bq_aw];

	logic [fetch_pkg::bq_aw-1:0] rd_ptr;
	logic [fetch_pkg::bq_aw-1:0] wr_ptr;
	logic [fetch_pkg::bq_aw:0] count; // 0 to 16

	always_ff @(posedge CLK) begin
		if (!rst_n || flush) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (push) wr_ptr <= wr_ptr + 1'b1;
			if (pop) rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ; // both or neither
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (push) begin
			mem[wr_ptr] <= din;
		end
	end

	assign dout = mem[rd_ptr]; // oldest entry
	assign full = count[fetch_pkg::bq_aw]; // only set at 16
	assign empty = (count == '0);

endmodule

// ==== source/return_stack.sv ====
// return address stack

`timescale 1ns/10ps

module return_stack (
	input logic CLK,
	input logic rst_n,
	input logic flush,
	input logic push,
	input logic pop,
	input logic [fetch_pkg::xlen-1:0] push_addr,
	output logic [fetch_pkg::xlen-1:0] top,
	output logic empty
);

	logic [fetch_pkg::xlen-1:0] mem [1 << fetch_pkg::ras_aw];

	logic [fetch_pkg::ras_aw-1:0] top_ptr; // newest entry
	logic [fetch_pkg::ras_aw-1:0] push_ptr;
	logic [fetch_pkg::ras_aw:0] count;

	assign push_ptr = top_ptr + 1'b1; // wraps over the oldest when full

	always_ff @(posedge CLK) begin
		if (!rst_n || flush) begin
			top_ptr <= '0;
			count <= '0;
		end else if (push) begin
			top_ptr <= push_ptr;
			// saturate, the deepest entry is lost
			if (!count[fetch_pkg::ras_aw]) count <= count + 1'b1;
		end else if (pop) begin
			top_ptr <= top_ptr - 1'b1;
			count <= count - 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (push) begin
			mem[push_ptr] <= push_addr;
		end
	end

	assign top = mem[top_ptr];
	assign empty = (count == '0);

endmodule

// ==== source/rv_isa_pkg.sv ====
// RISC-V instruction encodings

package rv_isa_pkg;

	// major opcodes of the control transfers
	localparam logic [6:0] op_jal = 7'b110_1111;
	localparam logic [6:0] op_jalr = 7'b110_0111;
	localparam logic [6:0] op_branch = 7'b110_0011;

	// link registers per the calling convention
	localparam logic [4:0] reg_zero = 5'd0;
	localparam logic [4:0] reg_ra = 5'd1;
	localparam logic [4:0] reg_t0 = 5'd5;

	typedef struct packed {
		logic imm20;
		logic [9:0] imm10_1;
		logic imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rv_j_t;

	typedef struct packed {
		logic imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic imm11;
		logic [6:0] opcode;
	} rv_b_t;

	typedef struct packed {
		logic [11:0] imm11_0;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rv_i_t;

	// the same fetched word seen through each format
	typedef union packed {
		rv_j_t j;
		rv_b_t b;
		rv_i_t i;
	} rv_instr_u;

endpackage

// ==== testbench/pc_gen_checker.sv ====
// queue and stack strobe checks

`timescale 1ns/10ps

module pc_gen_checker #(
	parameter bit check_full = 1'b1
) (
	input logic CLK,
	input logic rst_n,
	input logic flush,
	input logic push,
	input logic pop,
	input logic full,
	input logic empty
);

	if (check_full) begin : g_full
		// flush wins over a push in the same cycle
		a_push_full: assert property (@(posedge CLK) disable iff (!rst_n)
			!(push && full && !flush))
			else $error("push while full");
	end

	a_pop_empty: assert property (@(posedge CLK) disable iff (!rst_n)
		!(pop && empty))
		else $error("pop while empty");

endmodule

bind resolve_fifo pc_gen_checker u_bq_chk (
	.CLK   (CLK),
	.rst_n (rst_n),
	.flush (flush),
	.push  (push),
	.pop   (pop),
	.full  (full),
	.empty (empty)
);

// a full stack wraps on push, so only pops are checked
bind return_stack pc_gen_checker #(.check_full(1'b0)) u_ras_chk (
	.CLK   (CLK),
	.rst_n (rst_n),
	.flush (flush),
	.push  (push),
	.pop   (pop),
	.full  (1'b0),
	.empty (empty)
);

// ==== testbench/pc_gen_tb.sv ====
// fetch address generator testbench

`timescale 1ns/10ps

module pc_gen_tb;

	localparam int k_nop = 0;
	localparam int k_rvc = 1;
	localparam int k_br = 2;
	localparam int k_jal = 3;
	localparam int k_call = 4;
	localparam int k_ret = 5;
	localparam int k_jalr = 6;

	typedef struct packed {
		logic [31:0] instr;
		logic ready;
		logic qfull;
		logic exc;
		logic [63:0] epc;
		logic jv;
		logic [63:0] jpc;
		logic bv;
		logic bt;
		logic exp_valid;
		logic exp_mis;
		logic [63:0] exp_pc;
	} row_t;

	logic CLK;
	logic rst_n;
	logic [31:0] instr;
	logic fetch_ready;
	logic queue_full;
	logic exception;
	logic [63:0] exception_pc;
	logic jalr_valid;
	logic [63:0] jalr_pc;
	logic bru_valid;
	logic bru_taken;
	logic [63:0] fetch_pc;
	logic fetch_valid;
	logic mispredict;

	row_t rows[$];
	string names[$];
	logic [63:0] mpc; // reference fetch pc
	logic [64:0] mbq[$]; // {pred_taken, alt_pc}
	logic [63:0] mras[$];
	logic [31:0] rng = 32'h6f69_37e6;
	int cycles = 0;
	int limit = 1000;
	int n_pass = 0;
	int n_fail = 0;
	int row_bad;

	pc_gen DUT (.*);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycles++;
		if (cycles > limit) begin
			$display("timeout: the run did not finish within %0d cycles", limit);
			$display("Test failed");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s ^= s << 13;
		s ^= s >> 17;
		s ^= s << 5;
		return s;
	endfunction

	// even offset within the B-type reach
	function automatic logic [63:0] rand_imm(input logic neg);
		logic [63:0] v;
		rng = xorshift(rng);
		v = 64'((rng % 1000) + 1) * 2;
		return neg ? -v : v;
	endfunction

	function automatic logic [31:0] encode(input int kind, input logic [63:0] imm);
		case (kind)
			k_rvc: return 32'h0000_0001; // c.nop
			k_br: return {imm[12], imm[10:5], 5'd2, 5'd1, 3'b000, imm[4:1], imm[11], 7'h63};
			k_jal: return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, 7'h6f};
			k_call: return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'h6f};
			k_ret: return {12'd0, 5'd1, 3'b000, 5'd0, 7'h67};
			k_jalr: return {12'd0, 5'd6, 3'b000, 5'd0, 7'h67};
			default: return 32'h0000_0013; // addi x0, x0, 0
		endcase
	endfunction

	// reference rules for one cycle, then update the model state
	task automatic add_row(input string name, input int kind, input logic [63:0] imm,
		input logic ready, input logic qfull, input logic exc, input logic [63:0] epc,
		input logic jv, input logic [63:0] jpc, input logic bv, input logic bt);
		row_t r;
		logic [63:0] seq;
		logic [63:0] target;
		logic is_br;
		logic is_jalr;
		logic ret_ok;
		logic taken;
		logic mis;
		logic hold;
		is_br = (kind == k_br);
		is_jalr = (kind == k_ret) || (kind == k_jalr);
		ret_ok = (kind == k_ret) && (mras.size() > 0);
		seq = mpc + ((kind == k_rvc) ? 64'd2 : 64'd4);
		taken = (kind == k_jal) || (kind == k_call) || is_jalr || (is_br && imm[63]);
		target = is_jalr ? (ret_ok ? mras[$] : jpc) : mpc + imm;
		mis = bv && (bt != mbq[0][64]);
		hold = (is_br && mbq.size() == 16) || (is_jalr && !ret_ok && !jv) || qfull || !ready;
		r = '{encode(kind, imm), ready, qfull, exc, epc, jv, jpc, bv, bt,
			!hold || exc || mis, mis, 64'd0};
		if (exc) r.exp_pc = epc;
		else if (mis) r.exp_pc = mbq[0][63:0];
		else if (hold) r.exp_pc = mpc;
		else r.exp_pc = taken ? target : seq;
		if (exc || mis) begin
			mbq.delete();
			mras.delete();
		end else begin
			if (bv) void'(mbq.pop_front());
			if (!hold && is_br) mbq.push_back({taken, taken ? seq : target});
			if (!hold && kind == k_call) begin
				if (mras.size() == 16) void'(mras.pop_front()); // oldest lost
				mras.push_back(seq);
			end
			if (!hold && ret_ok) void'(mras.pop_back());
		end
		mpc = r.exp_pc;
		rows.push_back(r);
		names.push_back(name);
	endtask

	task automatic flow(input string name, input int kind, input logic [63:0] imm);
		add_row(name, kind, imm, 1, 0, 0, 0, 0, 0, 0, 0);
	endtask

	initial begin
		rst_n = 1'b0;
		instr = 32'h0000_0013;
		fetch_ready = 1'b0;
		queue_full = 1'b0;
		exception = 1'b0;
		exception_pc = '0;
		jalr_valid = 1'b0;
		jalr_pc = '0;
		bru_valid = 1'b0;
		bru_taken = 1'b0;
		mpc = 64'h8000_0000;

		flow("plain step", k_nop, 0);
		flow("compressed step", k_rvc, 0);
		add_row("fetch_ready low", k_nop, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		add_row("queue_full", k_nop, 0, 1, 1, 0, 0, 0, 0, 0, 0);
		flow("backward branch", k_br, rand_imm(1));
		flow("forward branch", k_br, rand_imm(0));
		flow("jal", k_jal, rand_imm(0));
		flow("jal back", k_jal, rand_imm(1));
		flow("call", k_call, rand_imm(0));
		flow("plain in callee", k_nop, 0);
		flow("return", k_ret, 0);
		flow("jalr wait", k_jalr, 0);
		flow("jalr wait again", k_jalr, 0);
		add_row("jalr target", k_jalr, 0, 1, 0, 0, 0, 1, 64'h8000_4000, 0, 0);
		add_row("resolve correct", k_nop, 0, 1, 0, 0, 0, 0, 0, 1, 1);
		add_row("resolve wrong", k_nop, 0, 1, 0, 0, 0, 0, 0, 1, 1);
		flow("after redirect", k_nop, 0);
		flow("call again", k_call, rand_imm(0));
		flow("forward branch 2", k_br, rand_imm(0));
		add_row("exception over mispredict", k_nop, 0, 1, 0, 1, 64'h8000_0100, 0, 0, 1, 1);
		flow("return after flush", k_ret, 0);
		add_row("return via execute", k_ret, 0, 1, 0, 0, 0, 1, 64'h8000_0200, 0, 0);
		flow("final step", k_nop, 0);
		limit = rows.size() + 3 + 50;

		repeat (3) @(posedge CLK);
		@(negedge CLK);
		rst_n = 1'b1;
		row_bad = 0;
		if (fetch_pc !== 64'h8000_0000) begin
			$display("FAIL fetch_pc got %h expected %h", fetch_pc, 64'h8000_0000);
			row_bad = 1;
		end
		if (mispredict !== 1'b0) begin
			$display("FAIL mispredict got %h expected %h", mispredict, 1'b0);
			row_bad = 1;
		end
		$display("reset: %s", row_bad ? "failed" : "ok");
		if (row_bad) n_fail++;
		else n_pass++;

		for (int i = 0; i < rows.size(); i++) begin
			row_bad = 0;
			instr = rows[i].instr;
			fetch_ready = rows[i].ready;
			queue_full = rows[i].qfull;
			exception = rows[i].exc;
			exception_pc = rows[i].epc;
			jalr_valid = rows[i].jv;
			jalr_pc = rows[i].jpc;
			bru_valid = rows[i].bv;
			bru_taken = rows[i].bt;
			#15;
			if (fetch_valid !== rows[i].exp_valid) begin
				$display("FAIL fetch_valid got %h expected %h", fetch_valid, rows[i].exp_valid);
				row_bad = 1;
			end
			if (mispredict !== rows[i].exp_mis) begin
				$display("FAIL mispredict got %h expected %h", mispredict, rows[i].exp_mis);
				row_bad = 1;
			end
			@(negedge CLK); // pc from the edge just past
			if (fetch_pc !== rows[i].exp_pc) begin
				$display("FAIL fetch_pc got %h expected %h", fetch_pc, rows[i].exp_pc);
				row_bad = 1;
			end
			$display("row %0d %s: %s", i, names[i], row_bad ? "failed" : "ok");
			if (row_bad) n_fail++;
			else n_pass++;
		end

		$display("passed %0d, failed %0d", n_pass, n_fail);
		if (n_fail == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
